//--- design/alu.sv
module alu (
  input  mips_pkg::word_t   a,
  input  mips_pkg::word_t   b,
  input  mips_pkg::alu_op_t op,
  output mips_pkg::word_t   result,
  output logic              zero
);
  import mips_pkg::*;

  logic less_signed;

  // signed compare for slt
  assign less_signed = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_and: begin
        result = a & b;
      end
      alu_or: begin
        result = a | b;
      end
      alu_slt: begin
        result = {31'd0, less_signed};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // used by beq/bne after a subtract
  assign zero = (result == '0);

endmodule

//--- design/control_unit.sv
module control_unit (
  input  mips_pkg::word_t instr,
  output mips_pkg::ctrl_t ctrl
);
  import mips_pkg::*;

  opcode_t opcode;
  funct_t  funct;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);

  always_comb begin
    // anything not matched below stays a no-op
    ctrl = '0;
    case (opcode)
      op_r_type: begin
        case (funct)
          fn_add: begin
            ctrl.reg_write  = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            ctrl.alu_op     = alu_add;
          end
          fn_sub: begin
            ctrl.reg_write  = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            ctrl.alu_op     = alu_sub;
          end
          fn_and: begin
            ctrl.reg_write  = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            ctrl.alu_op     = alu_and;
          end
          fn_or: begin
            ctrl.reg_write  = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            ctrl.alu_op     = alu_or;
          end
          fn_slt: begin
            ctrl.reg_write  = 1'b1;
            ctrl.reg_dst_rd = 1'b1;
            ctrl.alu_op     = alu_slt;
          end
          fn_jr: ctrl.jr = 1'b1;
          default: ctrl = '0;
        endcase
      end
      op_addi: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_add;
      end
      op_lw: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        ctrl.alu_op      = alu_add;
      end
      op_sw: begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_add;
      end
      // branches compare through the subtractor's zero flag
      op_beq: begin
        ctrl.branch_eq = 1'b1;
        ctrl.alu_op    = alu_sub;
      end
      op_bne: begin
        ctrl.branch_ne = 1'b1;
        ctrl.alu_op    = alu_sub;
      end
      op_j: ctrl.jump = 1'b1;
      op_jal: begin
        ctrl.jump      = 1'b1;
        ctrl.jal       = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

//--- design/instr_memory.sv
module instr_memory #(
  parameter int imem_depth = 256
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            run,
  input  logic            prog_valid,
  output logic            prog_ready,
  input  mips_pkg::word_t prog_addr,
  input  mips_pkg::word_t prog_data,
  input  mips_pkg::word_t fetch_addr,
  output mips_pkg::word_t instr
);
  import mips_pkg::*;

  localparam int addr_w = (imem_depth > 1) ? $clog2(imem_depth) : 1;

  word_t mem [imem_depth];

  logic prog_in_range;
  logic fetch_in_range;

  // loads only while the core is stopped
  assign prog_ready = !run && !reset;

  // byte address to word index, full-width compare so nothing aliases
  assign prog_in_range  = (prog_addr[31:2] < imem_depth);
  assign fetch_in_range = (fetch_addr[31:2] < imem_depth);

  always_ff @(posedge clk) begin
    if (prog_valid && prog_ready && prog_in_range) begin
      mem[prog_addr[addr_w+1:2]] <= prog_data;
    end
  end

  // past the end reads as zero, which decodes as a no-op
  always_comb begin
    if (fetch_in_range) begin
      instr = mem[fetch_addr[addr_w+1:2]];
    end else begin
      instr = '0;
    end
  end

endmodule

//--- design/mips_core.sv
module mips_core (
  input  logic              clk,
  input  logic              reset,
  input  logic              run,
  input  mips_pkg::word_t   instr,
  input  mips_pkg::ctrl_t   ctrl,
  input  mips_pkg::word_t   alu_result,
  input  logic              alu_zero,
  input  mips_pkg::word_t   dmem_rdata,
  output mips_pkg::word_t   pc,
  output mips_pkg::word_t   alu_a,
  output mips_pkg::word_t   alu_b,
  output mips_pkg::alu_op_t alu_op,
  output mips_pkg::word_t   dmem_addr,
  output mips_pkg::word_t   dmem_wdata,
  output logic              dmem_we,
  output logic              wb_valid,
  output mips_pkg::reg_addr_t wb_reg,
  output mips_pkg::word_t   wb_data,
  regfile_if.core           rf
);
  import mips_pkg::*;

  // instruction fields
  reg_addr_t   rs;
  reg_addr_t   rt;
  reg_addr_t   rd;
  logic [15:0] imm;
  logic [25:0] target;
  word_t       sign_imm;

  word_t     pc_plus4;
  word_t     branch_target;
  word_t     jump_target;
  word_t     next_pc;
  logic      branch_taken;
  logic      active;
  logic      reg_we;
  reg_addr_t write_reg;
  word_t     write_data;

  assign rs       = instr[25:21];
  assign rt       = instr[20:16];
  assign rd       = instr[15:11];
  assign imm      = instr[15:0];
  assign target   = instr[25:0];
  assign sign_imm = {{16{imm[15]}}, imm};

  // state changes only while running and out of reset
  assign active = run && !reset;

  // operand fetch and alu
  assign rf.ra1 = rs;
  assign rf.ra2 = rt;
  assign alu_a  = rf.rd1;
  assign alu_b  = ctrl.alu_src_imm ? sign_imm : rf.rd2;
  assign alu_op = ctrl.alu_op;

  // data memory, address from base plus offset
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rf.rd2;
  assign dmem_we    = active && ctrl.mem_write;

  // write back select
  assign write_reg  = ctrl.jal ? link_reg : (ctrl.reg_dst_rd ? rd : rt);
  assign write_data = ctrl.jal ? pc_plus4 : (ctrl.mem_to_reg ? dmem_rdata : alu_result);
  assign reg_we     = active && ctrl.reg_write;

  assign rf.wa = write_reg;
  assign rf.wd = write_data;
  assign rf.we = reg_we;

  // retire trace mirrors the register write
  assign wb_valid = reg_we && (write_reg != '0);
  assign wb_reg   = write_reg;
  assign wb_data  = write_data;

  // next pc
  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {sign_imm[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], target, 2'b00};
  assign branch_taken  = (ctrl.branch_eq && alu_zero) || (ctrl.branch_ne && !alu_zero);

  always_comb begin
    if (ctrl.jr) begin
      next_pc = rf.rd1;
    end else if (ctrl.jump) begin
      next_pc = jump_target;
    end else if (branch_taken) begin
      next_pc = branch_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (run) begin
      pc <= next_pc;
    end
  end

endmodule

//--- design/mips_pkg.sv
package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // jal writes its return address here
  localparam reg_addr_t link_reg = 5'd31;

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    op_r_type = 6'h00,
    op_j      = 6'h02,
    op_jal    = 6'h03,
    op_beq    = 6'h04,
    op_bne    = 6'h05,
    op_addi   = 6'h08,
    op_lw     = 6'h23,
    op_sw     = 6'h2b
  } opcode_t;

  // r-type function field, instr[5:0]
  typedef enum logic [5:0] {
    fn_jr  = 6'h08,
    fn_add = 6'h20,
    fn_sub = 6'h22,
    fn_and = 6'h24,
    fn_or  = 6'h25,
    fn_slt = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4
  } alu_op_t;

  // all zero means no-op
  typedef struct packed {
    logic    mem_to_reg;
    logic    mem_write;
    logic    branch_eq;
    logic    branch_ne;
    logic    alu_src_imm;
    logic    reg_dst_rd;
    logic    reg_write;
    logic    jump;
    logic    jal;
    logic    jr;
    alu_op_t alu_op;
  } ctrl_t;

endpackage

//--- design/mips_top.sv
module mips_top #(
  parameter int imem_depth = 256
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  input  logic                prog_valid,
  output logic                prog_ready,
  input  mips_pkg::word_t     prog_addr,
  input  mips_pkg::word_t     prog_data,
  output mips_pkg::word_t     pc,
  output mips_pkg::word_t     dmem_addr,
  output mips_pkg::word_t     dmem_wdata,
  output logic                dmem_we,
  input  mips_pkg::word_t     dmem_rdata,
  output logic                wb_valid,
  output mips_pkg::reg_addr_t wb_reg,
  output mips_pkg::word_t     wb_data
);
  import mips_pkg::*;

  word_t   instr;
  ctrl_t   ctrl;
  word_t   alu_a;
  word_t   alu_b;
  alu_op_t alu_op;
  word_t   alu_result;
  logic    alu_zero;

  regfile_if rf_bus ();

  // pc doubles as the fetch address
  instr_memory #(
    .imem_depth (imem_depth)
  ) u_imem (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .prog_valid (prog_valid),
    .prog_ready (prog_ready),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .fetch_addr (pc),
    .instr      (instr)
  );

  control_unit u_ctrl (
    .instr (instr),
    .ctrl  (ctrl)
  );

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  register_file u_rf (
    .clk   (clk),
    .reset (reset),
    .rf    (rf_bus.rf)
  );

  mips_core u_core (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .instr      (instr),
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .alu_zero   (alu_zero),
    .dmem_rdata (dmem_rdata),
    .pc         (pc),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_op     (alu_op),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data),
    .rf         (rf_bus.core)
  );

endmodule

//--- design/regfile_if.sv
interface regfile_if;
  import mips_pkg::*;

  // two read ports
  reg_addr_t ra1;
  reg_addr_t ra2;
  word_t     rd1;
  word_t     rd2;

  // one write port, committed at the rising edge
  reg_addr_t wa;
  word_t     wd;
  logic      we;

  modport core (
    output ra1, ra2, wa, wd, we,
    input  rd1, rd2
  );

  modport rf (
    input  ra1, ra2, wa, wd, we,
    output rd1, rd2
  );

endinterface

//--- design/register_file.sv
module register_file (
  input  logic         clk,
  input  logic         reset,
  regfile_if.rf        rf
);
  import mips_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.we && rf.wa != '0) begin
      // writes to r0 are dropped
      regs[rf.wa] <= rf.wd;
    end
  end

  // combinational reads, r0 hardwired to zero
  always_comb begin
    if (rf.ra1 == '0) begin
      rf.rd1 = '0;
    end else begin
      rf.rd1 = regs[rf.ra1];
    end
  end

  always_comb begin
    if (rf.ra2 == '0) begin
      rf.rd2 = '0;
    end else begin
      rf.rd2 = regs[rf.ra2];
    end
  end

endmodule

//--- filelist.f
design/mips_pkg.sv
design/regfile_if.sv
design/control_unit.sv
design/alu.sv
design/register_file.sv
design/instr_memory.sv
design/mips_core.sv
design/mips_top.sv
testbench/mips_checker.sv
testbench/tb_mips_top.sv

//--- run.sh
#!/bin/sh
# compile and run the mips_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

if ! verilator --binary --assert --timing -Wno-fatal --top-module tb_mips_top \
    -Mdir "$build_dir" -f filelist.f; then
  echo "verilator build failed"
  exit 1
fi

# raise the error limit so assertion failures reach the testbench summary
if ! "./$build_dir/Vtb_mips_top" +verilator+error+limit+1000 > "$log" 2>&1; then
  cat "$log"
  echo "simulation exited with an error status"
  exit 1
fi

cat "$log"

if grep -q "^Result: PASSED$" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

//--- testbench/mips_checker.sv
module mips_checker (
  input logic                clk,
  input logic                reset,
  input logic                run,
  input logic                prog_ready,
  input mips_pkg::word_t     pc,
  input logic                dmem_we,
  input logic                wb_valid,
  input mips_pkg::reg_addr_t wb_reg
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // no stores or retires unless running and out of reset
  quiet_when_stopped: assert property (@(posedge clk) (reset || !run) |-> (!dmem_we && !wb_valid))
    else begin
      fail_count = fail_count + 1;
      $error("store or register write while stopped or in reset");
    end

  no_r0_retire: assert property (@(posedge clk) wb_valid |-> (wb_reg != 5'd0))
    else begin
      fail_count = fail_count + 1;
      $error("retire trace reports a write to register 0");
    end

  pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
    else begin
      fail_count = fail_count + 1;
      $error("pc is not word aligned");
    end

  // stopped core keeps its pc
  pc_holds: assert property (@(posedge clk) (!reset && !run) |=> $stable(pc))
    else begin
      fail_count = fail_count + 1;
      $error("pc moved while the core was stopped");
    end

  no_load_while_running: assert property (@(posedge clk) run |-> !prog_ready)
    else begin
      fail_count = fail_count + 1;
      $error("program port ready while the core runs");
    end

endmodule

bind mips_top mips_checker chk0 (
  .clk        (clk),
  .reset      (reset),
  .run        (run),
  .prog_ready (prog_ready),
  .pc         (pc),
  .dmem_we    (dmem_we),
  .wb_valid   (wb_valid),
  .wb_reg     (wb_reg)
);

//--- testbench/tb_mips_top.sv
module tb_mips_top;
  timeunit 1ns;
  timeprecision 1ps;
  import mips_pkg::*;

  // the full run needs only a few hundred cycles
  localparam int cycle_limit = 4000;

  logic clk;
  logic reset;
  logic run;
  logic prog_valid;
  logic prog_ready;
  word_t prog_addr;
  word_t prog_data;
  word_t pc;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic dmem_we;
  word_t dmem_rdata;
  logic wb_valid;
  reg_addr_t wb_reg;
  word_t wb_data;

  word_t dmem [256];
  word_t model_imem [256];
  word_t model_dmem [256];
  word_t model_regs [32];
  word_t model_pc;
  word_t prog_q [$];
  word_t loop_prog [$];
  logic [36:0] trace_q [$];
  int errors = 0;
  int passed = 0;
  int failed = 0;
  int failures_seen = 0;
  int cycles = 0;

  mips_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // data memory with a combinational read and a write at the edge
  assign dmem_rdata = dmem[dmem_addr[9:2]];
  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  function automatic word_t r_instr(input logic [5:0] fn, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [4:0] rd);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t i_instr(input logic [5:0] op, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t j_instr(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic expect_word(input string what, input word_t got, input word_t want);
    assert (got == want) else begin
      errors++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  // steps one ISA instruction and compares it with the DUT in this cycle
  task automatic check_step();
    word_t ins, a, b, simm, p4, npc, wdat, addr;
    logic [4:0] wreg;
    logic mwe;
    ins = (model_pc < 32'd1024) ? model_imem[model_pc[9:2]] : '0;
    a = model_regs[ins[25:21]];
    b = model_regs[ins[20:16]];
    simm = {{16{ins[15]}}, ins[15:0]};
    p4 = model_pc + 32'd4;
    addr = a + simm;
    npc = p4;
    wreg = 5'd0;
    wdat = '0;
    mwe = 1'b0;
    case (ins[31:26])
      6'h00: begin
        wreg = ins[15:11];
        case (ins[5:0])
          6'h20: wdat = a + b;
          6'h22: wdat = a - b;
          6'h24: wdat = a & b;
          6'h25: wdat = a | b;
          6'h2a: wdat = {31'd0, $signed(a) < $signed(b)};
          6'h08: begin
            wreg = 5'd0;
            npc = a;
          end
          default: wreg = 5'd0;
        endcase
      end
      6'h08: begin
        wreg = ins[20:16];
        wdat = addr;
      end
      6'h23: begin
        wreg = ins[20:16];
        wdat = model_dmem[addr[9:2]];
      end
      6'h2b: mwe = 1'b1;
      6'h04: if (a == b) npc = p4 + {simm[29:0], 2'b00};
      6'h05: if (a != b) npc = p4 + {simm[29:0], 2'b00};
      6'h02: npc = {p4[31:28], ins[25:0], 2'b00};
      6'h03: begin
        npc = {p4[31:28], ins[25:0], 2'b00};
        wreg = 5'd31;
        wdat = p4;
      end
      default: ;
    endcase
    expect_word("pc", pc, model_pc);
    expect_word("wb_valid", 32'(wb_valid), 32'(wreg != 5'd0));
    if (wreg != 5'd0) begin
      expect_word("wb_reg", 32'(wb_reg), 32'(wreg));
      expect_word("wb_data", wb_data, wdat);
      model_regs[wreg] = wdat;
    end
    expect_word("dmem_we", 32'(dmem_we), 32'(mwe));
    if (mwe) begin
      expect_word("dmem_addr", dmem_addr, addr);
      expect_word("dmem_wdata", dmem_wdata, b);
      model_dmem[addr[9:2]] = b;
    end
    if (wb_valid) trace_q.push_back({wb_reg, wb_data});
    model_pc = npc;
  endtask

  // outputs are settled mid-cycle
  always @(negedge clk) begin
    if (reset) begin
      model_pc = '0;
      for (int i = 0; i < 32; i++) model_regs[i] = '0;
    end else if (run) begin
      check_step();
    end
  end

  task automatic apply_reset();
    reset = 1'b1;
    repeat (3) begin
      @(posedge clk);
      #2;
    end
    reset = 1'b0;
  endtask

  // random idle gaps between words and valid held until ready
  task automatic load_program();
    int gap;
    foreach (prog_q[i]) begin
      gap = $urandom_range(0, 2);
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
      prog_valid = 1'b1;
      prog_addr = 32'(i * 4);
      prog_data = prog_q[i];
      model_imem[i] = prog_q[i];
      @(posedge clk);
      while (!prog_ready) @(posedge clk);
      #2;
      prog_valid = 1'b0;
    end
  endtask

  // programs end in a jump to themselves
  task automatic run_to_halt(input word_t halt_pc);
    run = 1'b1;
    while (pc != halt_pc) begin
      @(posedge clk);
      #2;
    end
    repeat (2) begin
      @(posedge clk);
      #2;
    end
    run = 1'b0;
  endtask

  task automatic finish_test(input string name);
    int total;
    total = errors + dut0.chk0.fail_count;
    if (total == failures_seen) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d failed checks", name, total - failures_seen);
    end
    failures_seen = total;
  endtask

  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: tests did not finish within %0d cycles", cycle_limit);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [36:0] first_trace [$];
    void'($urandom(21));
    reset = 1'b1;
    run = 1'b0;
    prog_valid = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    for (int i = 0; i < 256; i++) begin
      dmem[i] = '0;
      model_dmem[i] = '0;
      model_imem[i] = '0;
    end

    apply_reset();
    prog_q = '{i_instr(6'h08, 0, 1, 16'($urandom)), i_instr(6'h08, 0, 2, 16'($urandom)),
               r_instr(6'h20, 1, 2, 3), j_instr(6'h02, 3)};
    load_program();
    run = 1'b1;
    // this word must be refused while running
    prog_valid = 1'b1;
    prog_addr = '0;
    prog_data = i_instr(6'h08, 0, 1, 16'h7777);
    repeat (2) begin
      @(posedge clk);
      #2;
    end
    prog_valid = 1'b0;
    run_to_halt(32'd12);
    apply_reset();
    run_to_halt(32'd12);
    finish_test("load handshake");

    apply_reset();
    prog_q = '{i_instr(6'h08, 0, 1, 16'($urandom)), i_instr(6'h08, 0, 2, 16'($urandom)),
               r_instr(6'h20, 1, 2, 3), r_instr(6'h22, 1, 2, 4), r_instr(6'h24, 1, 2, 5),
               r_instr(6'h25, 1, 2, 6), r_instr(6'h2a, 1, 2, 7), r_instr(6'h2a, 2, 1, 8),
               i_instr(6'h08, 1, 0, 16'd5), j_instr(6'h02, 9)};
    load_program();
    run_to_halt(32'd36);
    finish_test("alu instructions");

    apply_reset();
    // the store at address 0 is fetched while the core is stopped or in reset
    prog_q = '{i_instr(6'h2b, 0, 0, 16'h0080), i_instr(6'h08, 0, 1, 16'h0040),
               i_instr(6'h08, 0, 2, 16'($urandom)), i_instr(6'h2b, 1, 2, 16'd8),
               i_instr(6'h2b, 1, 1, 16'hfffc), i_instr(6'h23, 1, 3, 16'd8),
               i_instr(6'h23, 1, 4, 16'hfffc), j_instr(6'h02, 7)};
    load_program();
    run_to_halt(32'd28);
    finish_test("load and store");

    apply_reset();
    loop_prog = '{i_instr(6'h08, 0, 1, 16'd5), i_instr(6'h08, 0, 2, 16'd5),
                  i_instr(6'h08, 0, 3, 16'd0), i_instr(6'h04, 1, 2, 16'd1),
                  i_instr(6'h08, 0, 4, 16'd99), i_instr(6'h05, 1, 2, 16'd1),
                  i_instr(6'h08, 3, 3, 16'd1), i_instr(6'h05, 3, 1, 16'hfffe),
                  i_instr(6'h04, 3, 0, 16'd1), j_instr(6'h02, 9)};
    prog_q = loop_prog;
    load_program();
    run_to_halt(32'd36);
    finish_test("branches");

    apply_reset();
    prog_q = '{j_instr(6'h03, 4), i_instr(6'h08, 0, 5, 16'd7), j_instr(6'h02, 6),
               i_instr(6'h08, 0, 6, 16'd1), i_instr(6'h08, 0, 7, 16'd3),
               r_instr(6'h08, 31, 0, 0), j_instr(6'h02, 6)};
    load_program();
    run_to_halt(32'd24);
    finish_test("jumps");

    apply_reset();
    prog_q = loop_prog;
    load_program();
    trace_q.delete();
    run_to_halt(32'd36);
    first_trace = trace_q;
    apply_reset();
    run = 1'b1;
    repeat (6) begin
      @(posedge clk);
      #2;
    end
    // reset lands inside the loop
    apply_reset();
    expect_word("pc after reset", pc, '0);
    trace_q.delete();
    run_to_halt(32'd36);
    expect_word("trace length", 32'(trace_q.size()), 32'(first_trace.size()));
    foreach (first_trace[i]) begin
      if (i < trace_q.size()) begin
        expect_word("trace reg", 32'(trace_q[i][36:32]), 32'(first_trace[i][36:32]));
        expect_word("trace data", trace_q[i][31:0], first_trace[i][31:0]);
      end
    end
    finish_test("reset mid-program");

    $display("%0d tests passed, %0d failed, %0d failed checks", passed, failed, failures_seen);
    if (failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
